//--- filelist.f
+incdir+rtl
rtl/cnn_types_pkg.sv
rtl/wb_regs_pkg.sv
rtl/block_if.sv
rtl/conv_regs.sv
rtl/layer_sequencer.sv
rtl/block_fetcher.sv
rtl/window_streamer.sv
rtl/conv_read_top.sv
testbench/conv_read_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the layer-one reader testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    -f filelist.f \
    --top-module conv_read_tb \
    -o conv_read_sim

./obj_dir/conv_read_sim

//--- testbench/conv_read_tb.sv
////////////////////////////////////////
// Testbench for the layer-one reader that checks
// every stream beat against a software model
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "conv_cfg.svh"

module conv_read_tb;

    localparam int BLOCK_BEATS     = `CONV_TAPS + 2;  // Header, taps, command
    localparam int BLOCKS          = `CONV_BLOCK_DIM * `CONV_BLOCK_DIM;
    localparam int TOTAL_BEATS     = (2 + 1) * BLOCKS * BLOCK_BEATS;
    localparam int WATCHDOG_CYCLES = 3 * TOTAL_BEATS + 2000;

    typedef struct packed {
        logic [1:0] kind;
        logic [7:0] o0;
        logic [7:0] o1;
        logic [7:0] o2;
        logic [7:0] o3;
        logic [7:0] prm;
    } beat_t;

    logic                          clk;
    logic                          reset;
    logic                          wb_cyc;
    logic                          wb_stb;
    logic                          wb_we;
    logic [`CONV_WB_ADDR_W-1:0]    wb_adr;
    logic [31:0]                   wb_dat_w;
    logic [31:0]                   wb_dat_r;
    logic                          wb_ack;
    logic [`CONV_IMG_ADDR_W-1:0]   img_addr;
    cnn_types_pkg::pixel_t         img_bank0;
    cnn_types_pkg::pixel_t         img_bank1;
    cnn_types_pkg::pixel_t         img_bank2;
    cnn_types_pkg::pixel_t         img_bank3;
    logic [`CONV_PARAM_ADDR_W-1:0] param_addr;
    cnn_types_pkg::pixel_t         param_data;
    logic                          stream_valid;
    cnn_types_pkg::beat_kind_t     stream_kind;
    cnn_types_pkg::pixel_t         out0;
    cnn_types_pkg::pixel_t         out1;
    cnn_types_pkg::pixel_t         out2;
    cnn_types_pkg::pixel_t         out3;
    cnn_types_pkg::pixel_t         out_param;

    logic [7:0]                    image [`CONV_IMG_DIM][`CONV_IMG_DIM];
    logic [7:0]                    bank_mem [4][1 << `CONV_IMG_ADDR_W];
    logic [7:0]                    param_mem [1 << `CONV_PARAM_ADDR_W];
    logic [`CONV_IMG_ADDR_W-1:0]   img_addr_q;
    logic [`CONV_PARAM_ADDR_W-1:0] param_addr_q;
    beat_t                         expected [$];
    int                            beat_count;
    logic [31:0]                   rd;

    conv_read_top conv_read_top_inst (.*);

    always #50 clk = ~clk;

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Both memories answer one cycle after the address
    always @(posedge clk) begin
        img_addr_q   <= img_addr;
        param_addr_q <= param_addr;
    end

    always @(posedge clk) begin
        #1;
        img_bank0  = bank_mem[0][img_addr_q];
        img_bank1  = bank_mem[1][img_addr_q];
        img_bank2  = bank_mem[2][img_addr_q];
        img_bank3  = bank_mem[3][img_addr_q];
        param_data = param_mem[param_addr_q];
    end

    // Single Wishbone classic access with ack expected after one cycle
    task automatic wb_access(input logic we, input logic [`CONV_WB_ADDR_W-1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 16) begin
                $display("Wishbone access got no ack within 16 cycles");
                $display("TB FAILED");
                $fatal(1, "no ack");
            end
        end while (!wb_ack);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        check_equal("wb_ack latency", 32'(waited), 32'd1);
        @(posedge clk);
        #1;
        check_equal("wb_ack", {31'd0, wb_ack}, 32'd0);  // Single-cycle ack
    endtask

    task automatic wb_write(input logic [`CONV_WB_ADDR_W-1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [`CONV_WB_ADDR_W-1:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'd0, data);
    endtask

    // Expected beats of a whole run with blocks row-major inside each filter
    task automatic build_expected(input int nf);
        beat_t      b;
        logic [7:0] lane [4];
        int         base;
        for (int f = 0; f < nf; f++) begin
            base = f * `CONV_PARAM_STRIDE;
            for (int i = 0; i < `CONV_BLOCK_DIM; i++) begin
                for (int j = 0; j < `CONV_BLOCK_DIM; j++) begin
                    b.kind = cnn_types_pkg::BEAT_HEADER;
                    b.o0   = 8'd0;
                    b.o1   = 8'(`CONV_TAPS);
                    b.o2   = 8'd0;
                    b.o3   = 8'd0;
                    b.prm  = param_mem[base];  // Bias
                    expected.push_back(b);
                    for (int t = 0; t < `CONV_TAPS; t++) begin
                        for (int k = 0; k < 4; k++)
                            lane[k] = image[2 * i + k / 2 + t / 3][2 * j + k % 2 + t % 3];
                        b.kind = cnn_types_pkg::BEAT_TAP;
                        b.o0   = lane[0];
                        b.o1   = lane[1];
                        b.o2   = lane[2];
                        b.o3   = lane[3];
                        b.prm  = param_mem[base + 1 + t];
                        expected.push_back(b);
                    end
                    b.kind = cnn_types_pkg::BEAT_CMD;
                    b.o0   = `CONV_SSFR_OP;
                    b.o1   = 8'd0;
                    b.o2   = 8'd0;
                    b.o3   = 8'd0;
                    b.prm  = `CONV_SSFR_CFG;
                    expected.push_back(b);
                end
            end
        end
    endtask

    // Outputs are stable by the falling edge
    always @(negedge clk) begin
        beat_t exp;
        if (!reset && stream_valid) begin
            if (expected.size() == 0) begin
                $display("stream_valid high with no beat left in the model");
                $display("TB FAILED");
                $fatal(1, "extra beat");
            end else begin
                exp = expected.pop_front();
                check_equal("stream_kind", 32'(stream_kind), 32'(exp.kind));
                check_equal("out0", 32'(out0), 32'(exp.o0));
                check_equal("out1", 32'(out1), 32'(exp.o1));
                check_equal("out2", 32'(out2), 32'(exp.o2));
                check_equal("out3", 32'(out3), 32'(exp.o3));
                check_equal("out_param", 32'(out_param), 32'(exp.prm));
                beat_count++;
            end
        end
    end

    // Starts a run of nf filters and follows it to done
    task automatic run_layer(input int nf);
        beat_count = 0;
        build_expected(nf);
        wb_write(wb_regs_pkg::REG_FILTERS, 32'(nf));
        wb_write(wb_regs_pkg::REG_CTRL, 32'd1);
        wb_read(wb_regs_pkg::REG_STATUS, rd);
        check_equal("wb_dat_r STATUS", rd, 32'd1);  // Busy with done cleared
        wb_write(wb_regs_pkg::REG_CTRL, 32'd1);      // Ignored while busy
        do
            wb_read(wb_regs_pkg::REG_STATUS, rd);
        while (!rd[1]);
        check_equal("wb_dat_r STATUS", rd, 32'd2);
        repeat (100) @(posedge clk);  // No stray beats after the last one
        check_equal("beat count", 32'(beat_count), 32'(nf * BLOCKS * BLOCK_BEATS));
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, run did not complete", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $fatal(1, "watchdog");
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = 32'd0;
        img_bank0  = 8'd0;
        img_bank1  = 8'd0;
        img_bank2  = 8'd0;
        img_bank3  = 8'd0;
        param_data = 8'd0;
        beat_count = 0;
        void'($urandom(41));

        // Unused words carry an address pattern
        for (int a = 0; a < (1 << `CONV_IMG_ADDR_W); a++)
            for (int b = 0; b < 4; b++)
                bank_mem[b][a] = 8'(a ^ (a >> 8));
        for (int a = 0; a < (1 << `CONV_PARAM_ADDR_W); a++)
            param_mem[a] = 8'(a ^ (a >> 8));
        for (int r = 0; r < `CONV_IMG_DIM; r++) begin
            for (int c = 0; c < `CONV_IMG_DIM; c++) begin
                image[r][c] = 8'($urandom);
                bank_mem[2 * (r % 2) + c % 2][(r / 2) * `CONV_QUAD_DIM + c / 2] = image[r][c];
            end
        end
        for (int a = 0; a < 64 * `CONV_PARAM_STRIDE; a++)
            param_mem[a] = 8'($urandom);

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // Register defaults and ignored zero count
        wb_read(wb_regs_pkg::REG_STATUS, rd);
        check_equal("wb_dat_r STATUS", rd, 32'd0);
        wb_read(wb_regs_pkg::REG_FILTERS, rd);
        check_equal("wb_dat_r FILTERS", rd, 32'(`CONV_FILTERS_RESET));
        wb_write(wb_regs_pkg::REG_FILTERS, 32'd0);
        wb_read(wb_regs_pkg::REG_FILTERS, rd);
        check_equal("wb_dat_r FILTERS", rd, 32'(`CONV_FILTERS_RESET));
        wb_read(wb_regs_pkg::REG_CTRL, rd);
        check_equal("wb_dat_r CTRL", rd, 32'd0);

        run_layer(2);
        run_layer(1);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/conv_read_top.sv
////////////////////////////////////////
// Layer-one reader top: register block,
// sequencer, fetcher and streamer on plain ports
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "conv_cfg.svh"

module conv_read_top (
    input  logic                          clk,
    input  logic                          reset,
    // Wishbone classic slave
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [`CONV_WB_ADDR_W-1:0]    wb_adr,
    input  logic [31:0]                   wb_dat_w,
    output logic [31:0]                   wb_dat_r,
    output logic                          wb_ack,
    // Image banks and conv parameter RAM
    output logic [`CONV_IMG_ADDR_W-1:0]   img_addr,
    input  cnn_types_pkg::pixel_t         img_bank0,
    input  cnn_types_pkg::pixel_t         img_bank1,
    input  cnn_types_pkg::pixel_t         img_bank2,
    input  cnn_types_pkg::pixel_t         img_bank3,
    output logic [`CONV_PARAM_ADDR_W-1:0] param_addr,
    input  cnn_types_pkg::pixel_t         param_data,
    // Beat stream to the MAC array
    output logic                          stream_valid,
    output cnn_types_pkg::beat_kind_t     stream_kind,
    output cnn_types_pkg::pixel_t         out0,
    output cnn_types_pkg::pixel_t         out1,
    output cnn_types_pkg::pixel_t         out2,
    output cnn_types_pkg::pixel_t         out3,
    output cnn_types_pkg::pixel_t         out_param
);

    logic                       start;
    logic                       layer_done;
    wb_regs_pkg::filter_count_t filter_count;
    cnn_types_pkg::block_cmd_t  cmd;
    logic                       cmd_valid;
    logic                       cmd_ready;

    block_if blk_if ();

    conv_regs conv_regs_inst (
        .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .layer_done, .start, .filter_count
    );

    layer_sequencer layer_sequencer_inst (
        .clk, .reset, .start, .filter_count, .cmd, .cmd_valid, .cmd_ready
    );

    block_fetcher block_fetcher_inst (
        .clk, .reset, .cmd, .cmd_valid, .cmd_ready, .img_addr,
        .img_bank0, .img_bank1, .img_bank2, .img_bank3, .blk(blk_if.fetcher)
    );

    window_streamer window_streamer_inst (
        .clk, .reset, .blk(blk_if.streamer), .param_addr, .param_data,
        .stream_valid, .stream_kind, .out0, .out1, .out2, .out3, .out_param, .layer_done
    );

endmodule

`default_nettype wire

//--- rtl/window_streamer.sv
////////////////////////////////////////
// Sends header, nine tap beats and the command
// beat for each block, reading params ahead
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "conv_cfg.svh"

module window_streamer (
    input  logic                          clk,
    input  logic                          reset,
    block_if.streamer                     blk,
    output logic [`CONV_PARAM_ADDR_W-1:0] param_addr,
    input  cnn_types_pkg::pixel_t         param_data,
    output logic                          stream_valid,
    output cnn_types_pkg::beat_kind_t     stream_kind,
    output cnn_types_pkg::pixel_t         out0,
    output cnn_types_pkg::pixel_t         out1,
    output cnn_types_pkg::pixel_t         out2,
    output cnn_types_pkg::pixel_t         out3,
    output cnn_types_pkg::pixel_t         out_param,
    output logic                          layer_done
);

    localparam logic [3:0] LAST_BEAT = 4'(`CONV_TAPS + 1);

    logic                            active;
    logic [3:0]                      beat;  // 0 header, 1..9 taps, 10 command
    logic [3:0]                      tap;
    cnn_types_pkg::block_buf_t       pix_q;
    logic [`CONV_PARAM_ADDR_W-1:0]   base_q;
    logic [`CONV_PARAM_ADDR_W-1:0]   new_base;
    logic                            last_q;
    logic                            take;
    cnn_types_pkg::pixel_t           lane [4];

    // Buffer index of lane k for tap t
    function automatic logic [3:0] window_index(input logic [1:0] k, input logic [3:0] t);
        logic [2:0] y;
        logic [2:0] x;
        y = 3'(t / 4'd3) + 3'(k[1]);
        x = 3'(t % 4'd3) + 3'(k[0]);
        return {y[1], x[1], y[0], x[0]};
    endfunction

    assign blk.ready = ~active | (beat == LAST_BEAT);  // Next block may follow the command beat
    assign take      = blk.valid & blk.ready;
    assign new_base  = `CONV_PARAM_ADDR_W'(blk.filter * `CONV_PARAM_STRIDE);

    // Word for the next beat, bias first at a transfer
    assign param_addr = blk.ready ? new_base
                                  : base_q + `CONV_PARAM_ADDR_W'(beat + 4'd1);

    assign stream_valid = active;
    assign tap          = beat - 4'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            active     <= 1'b0;
            beat       <= 4'd0;
            layer_done <= 1'b0;
        end else begin
            layer_done <= active && beat == LAST_BEAT && last_q;
            if (take) begin
                active <= 1'b1;
                beat   <= 4'd0;
            end else if (active) begin
                if (beat == LAST_BEAT)
                    active <= 1'b0;
                else
                    beat <= beat + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pix_q  <= blk.pixels;
            base_q <= new_base;
            last_q <= blk.last;
        end
    end

    always_comb begin
        for (int k = 0; k < 4; k++)
            lane[k] = pix_q[window_index(2'(k), tap)];
        stream_kind = cnn_types_pkg::BEAT_TAP;
        out0        = lane[0];
        out1        = lane[1];
        out2        = lane[2];
        out3        = lane[3];
        out_param   = param_data;  // Bias or weight
        if (beat == 4'd0) begin
            stream_kind = cnn_types_pkg::BEAT_HEADER;
            out0        = '0;
            out1        = `CONV_PIX_W'(`CONV_TAPS);  // MAC count
            out2        = '0;
            out3        = '0;
        end else if (beat == LAST_BEAT) begin
            stream_kind = cnn_types_pkg::BEAT_CMD;
            out0        = `CONV_SSFR_OP;
            out1        = '0;
            out2        = '0;
            out3        = '0;
            out_param   = `CONV_SSFR_CFG;
        end
    end

endmodule

`default_nettype wire

//--- rtl/block_fetcher.sv
////////////////////////////////////////
// Reads the four quads of a block from the
// image banks and offers the 16-pixel buffer
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "conv_cfg.svh"

module block_fetcher (
    input  logic                        clk,
    input  logic                        reset,
    input  cnn_types_pkg::block_cmd_t   cmd,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    output logic [`CONV_IMG_ADDR_W-1:0] img_addr,
    input  cnn_types_pkg::pixel_t       img_bank0,
    input  cnn_types_pkg::pixel_t       img_bank1,
    input  cnn_types_pkg::pixel_t       img_bank2,
    input  cnn_types_pkg::pixel_t       img_bank3,
    block_if.fetcher                    blk
);

    logic [3:0]                  cur_row;
    logic [3:0]                  cur_col;
    logic [1:0]                  quad;       // Quad being addressed
    logic                        fetching;
    logic                        rd_pending; // Bank data due this cycle
    logic [1:0]                  rd_quad;
    logic [`CONV_IMG_ADDR_W-1:0] quad_row;
    logic [`CONV_IMG_ADDR_W-1:0] quad_col;
    cnn_types_pkg::pixel_t       bank_data [4];

    assign bank_data[0] = img_bank0;
    assign bank_data[1] = img_bank1;
    assign bank_data[2] = img_bank2;
    assign bank_data[3] = img_bank3;

    // Quad order (i,j) (i,j+1) (i+1,j) (i+1,j+1)
    assign quad_row = `CONV_IMG_ADDR_W'(cur_row) + `CONV_IMG_ADDR_W'(quad[1]);
    assign quad_col = `CONV_IMG_ADDR_W'(cur_col) + `CONV_IMG_ADDR_W'(quad[0]);
    assign img_addr = `CONV_IMG_ADDR_W'(quad_row * `CONV_QUAD_DIM) + quad_col;

    assign cmd_ready = ~fetching & ~rd_pending & ~blk.valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetching   <= 1'b0;
            rd_pending <= 1'b0;
            blk.valid  <= 1'b0;
            quad       <= 2'd0;
        end else begin
            if (cmd_valid && cmd_ready) begin
                fetching <= 1'b1;
                quad     <= 2'd0;
            end else if (fetching) begin
                quad <= quad + 2'd1;
                if (quad == 2'd3)
                    fetching <= 1'b0;
            end
            rd_pending <= fetching;
            rd_quad    <= quad;
            if (rd_pending && rd_quad == 2'd3)
                blk.valid <= 1'b1;  // Buffer complete
            else if (blk.valid && blk.ready)
                blk.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            cur_row    <= cmd.block_row;
            cur_col    <= cmd.block_col;
            blk.filter <= cmd.filter;
            blk.last   <= cmd.last;
        end
        if (rd_pending) begin
            for (int k = 0; k < 4; k++)
                blk.pixels[{rd_quad, 2'(k)}] <= bank_data[k];
        end
    end

endmodule

`default_nettype wire

//--- rtl/layer_sequencer.sv
////////////////////////////////////////
// Walks filters and 12x12 block positions,
// one block command per handshake
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "conv_cfg.svh"

module layer_sequencer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  wb_regs_pkg::filter_count_t filter_count,
    output cnn_types_pkg::block_cmd_t  cmd,
    output logic                       cmd_valid,
    input  logic                       cmd_ready
);

    localparam logic [3:0] LAST_POS = 4'(`CONV_BLOCK_DIM - 1);

    cnn_types_pkg::seq_state_t  state;
    cnn_types_pkg::block_cmd_t  next_cmd;
    wb_regs_pkg::filter_count_t filter_limit;  // Latched at start
    logic                       col_wrap;
    logic                       row_wrap;

    assign col_wrap = (cmd.block_col == LAST_POS);
    assign row_wrap = (cmd.block_row == LAST_POS);

    // Row-major within a filter, then next filter
    always_comb begin
        next_cmd           = cmd;
        next_cmd.block_col = col_wrap ? 4'd0 : cmd.block_col + 4'd1;
        if (col_wrap) begin
            next_cmd.block_row = row_wrap ? 4'd0 : cmd.block_row + 4'd1;
            if (row_wrap)
                next_cmd.filter = cmd.filter + 6'd1;
        end
        next_cmd.last = (next_cmd.filter == filter_limit - 6'd1) &&
                        (next_cmd.block_row == LAST_POS) &&
                        (next_cmd.block_col == LAST_POS);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= cnn_types_pkg::SEQ_IDLE;
            cmd_valid <= 1'b0;
        end else begin
            case (state)
                cnn_types_pkg::SEQ_IDLE: begin
                    if (start) begin
                        state     <= cnn_types_pkg::SEQ_RUN;
                        cmd_valid <= 1'b1;
                    end
                end
                default: begin
                    if (cmd_valid && cmd_ready && cmd.last) begin
                        state     <= cnn_types_pkg::SEQ_IDLE;
                        cmd_valid <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cnn_types_pkg::SEQ_IDLE && start) begin
            cmd          <= '0;  // Block (0,0) of filter 0, never last
            filter_limit <= filter_count;
        end else if (cmd_valid && cmd_ready) begin
            cmd <= next_cmd;
        end
    end

endmodule

`default_nettype wire

//--- rtl/conv_regs.sv
////////////////////////////////////////
// Wishbone classic slave with control,
// status and filter-count registers
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "conv_cfg.svh"

module conv_regs (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [`CONV_WB_ADDR_W-1:0] wb_adr,
    input  logic [31:0]                wb_dat_w,
    output logic [31:0]                wb_dat_r,
    output logic                       wb_ack,
    input  logic                       layer_done,
    output logic                       start,
    output wb_regs_pkg::filter_count_t filter_count
);

    localparam int FC_W = $bits(wb_regs_pkg::filter_count_t);

    logic                   req;
    wb_regs_pkg::reg_addr_t addr;
    logic                   busy;
    logic                   done;

    // New access only, ack itself ends it
    assign req  = wb_cyc & wb_stb & ~wb_ack;
    assign addr = wb_regs_pkg::reg_addr_t'(wb_adr);

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack       <= 1'b0;
            start        <= 1'b0;
            busy         <= 1'b0;
            done         <= 1'b0;
            filter_count <= FC_W'(`CONV_FILTERS_RESET);
        end else begin
            wb_ack <= req;
            start  <= 1'b0;
            if (layer_done) begin
                busy <= 1'b0;
                done <= 1'b1;  // Sticky until next start
            end
            if (req && wb_we) begin
                case (addr)
                    wb_regs_pkg::REG_CTRL: begin
                        if (wb_dat_w[0] && !busy) begin
                            start <= 1'b1;
                            busy  <= 1'b1;
                            done  <= 1'b0;
                        end
                    end
                    wb_regs_pkg::REG_FILTERS: begin
                        if (wb_dat_w[FC_W-1:0] != '0)
                            filter_count <= wb_dat_w[FC_W-1:0];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Read data lands together with ack
    always_ff @(posedge clk) begin
        if (req) begin
            case (addr)
                wb_regs_pkg::REG_STATUS:  wb_dat_r <= {30'd0, done, busy};
                wb_regs_pkg::REG_FILTERS: wb_dat_r <= {{(32 - FC_W){1'b0}}, filter_count};
                default:                  wb_dat_r <= 32'd0;  // Control reads as zero
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/block_if.sv
////////////////////////////////////////
// One fetched 4x4 block on its way from the
// fetcher to the streamer, valid/ready handshake
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

interface block_if;

    cnn_types_pkg::block_buf_t  pixels;
    cnn_types_pkg::filter_idx_t filter;
    logic                       last;
    logic                       valid;
    logic                       ready;

    // Producer side, holds everything until ready
    modport fetcher(output pixels, output filter, output last, output valid,
                    input ready);

    modport streamer(input pixels, input filter, input last, input valid,
                     output ready);

endinterface

`default_nettype wire

//--- rtl/wb_regs_pkg.sv
////////////////////////////////////////
// Register map of the Wishbone control block
////////////////////////////////////////
`default_nettype none

`include "conv_cfg.svh"

package wb_regs_pkg;

    // Word offsets
    typedef enum logic [`CONV_WB_ADDR_W-1:0] {
        REG_CTRL    = 0,  // bit0 starts a run
        REG_STATUS  = 1,  // bit0 busy, bit1 done
        REG_FILTERS = 2
    } reg_addr_t;

    typedef logic [5:0] filter_count_t;

endpackage

`default_nettype wire

//--- rtl/cnn_types_pkg.sv
////////////////////////////////////////
// Datapath types shared by the sequencer,
// fetcher and streamer
////////////////////////////////////////
`default_nettype none

`include "conv_cfg.svh"

package cnn_types_pkg;

    // One pixel or one parameter word
    typedef logic [`CONV_PIX_W-1:0] pixel_t;

    // Filter index carried with each block
    typedef logic [5:0] filter_idx_t;

    // Quad-major block, index is 4*quad + bank
    typedef pixel_t [15:0] block_buf_t;

    typedef enum logic [1:0] {
        BEAT_HEADER,  // Bias and MAC count
        BEAT_TAP,     // Four lanes plus one weight
        BEAT_CMD      // Post-processing command
    } beat_kind_t;

    typedef enum logic [0:0] {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_t;

    typedef struct packed {
        logic [3:0]  block_row;
        logic [3:0]  block_col;
        filter_idx_t filter;
        logic        last;  // Final block of the run
    } block_cmd_t;

endpackage

`default_nettype wire

//--- rtl/conv_cfg.svh
////////////////////////////////////////
// Sizes, widths and command codes for the
// layer-one reader, included wherever needed
////////////////////////////////////////
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// Image geometry
`define CONV_IMG_DIM        26  // Pixels per side
`define CONV_QUAD_DIM       13  // 2x2 quads per side
`define CONV_BLOCK_DIM      12  // 4x4 block positions per side

// Kernel and parameter RAM layout
`define CONV_TAPS           9   // 3x3 kernel
`define CONV_PARAM_STRIDE   10  // Bias plus nine weights

// Datapath and address widths
`define CONV_PIX_W          8
`define CONV_IMG_ADDR_W     10
`define CONV_PARAM_ADDR_W   15

// Post-processing command beat for out0 and out_param
`define CONV_SSFR_OP        8'hC1
`define CONV_SSFR_CFG       8'h28

// Register block
`define CONV_WB_ADDR_W      2
`define CONV_FILTERS_RESET  32

`endif
